//--- hw/axis_pkg.sv
// AXI4-Stream field widths and the packed beat carried through the register slice
`default_nettype none

package axis_pkg;

    // Fixed beat geometry
    localparam int AXIS_DATA_BYTES = 4;          // tdata bytes per beat
    localparam int AXIS_DEST_WIDTH = 4;          // Routing field, passed through untouched
    localparam int AXIS_USER_WIDTH = 2;          // Sideband bits
    localparam int AXIS_ID_WIDTH   = 3;          // Stream identifier

    // One stream beat, 50 bits in total
    // MSB first: tdata sits on top, tid in the low bits
    typedef struct packed {
        logic [AXIS_DATA_BYTES*8-1:0] tdata;     // Payload word
        logic [AXIS_DATA_BYTES-1:0]   tstrb;     // Byte qualifier, data vs position
        logic [AXIS_DATA_BYTES-1:0]   tkeep;     // Byte qualifier, null bytes
        logic                         tlast;     // Packet boundary
        logic [AXIS_DEST_WIDTH-1:0]   tdest;     // Destination
        logic [AXIS_USER_WIDTH-1:0]   tuser;     // User sideband
        logic [AXIS_ID_WIDTH-1:0]     tid;       // Stream id
    } axis_beat_t;

endpackage

`default_nettype wire

//--- hw/skid_buffer.sv
// Skid buffer that registers the ready path and passes beats through with no added latency
`timescale 1ns/1ps
`default_nettype none

module skid_buffer #(
    parameter type payload_t = logic             // Any packed payload
) (
    input  logic     aclk,
    input  logic     rst_n,

    input  logic     rx_tvalid,                  // Upstream side
    output logic     rx_tready,                  // Registered, high while skid is empty
    input  payload_t rx_data,

    output logic     tx_tvalid,                  // Downstream side
    input  logic     tx_tready,
    output payload_t tx_data
);

    logic     full;                              // Skid register holds a beat
    logic     full_next;
    logic     load;                              // Capture incoming beat into skid
    payload_t skid_q;                            // Spare slot for one stalled beat

    // Beat accepted upstream but downstream not taking it
    assign load = rx_tvalid && rx_tready && !tx_tready;

    always_comb begin
        full_next = full;
        if (full && tx_tready) begin             // Stored beat drains
            full_next = 1'b0;
        end else if (load) begin                 // Beat lands in the skid slot
            full_next = 1'b1;
        end
    end

    // Control state
    // rx_tready kept as its own flop so the ready path starts at a register
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            full      <= 1'b0;
            rx_tready <= 1'b1;                   // Empty after reset
        end else begin
            full      <= full_next;
            rx_tready <= !full_next;
        end
    end

    // Payload slot
    always_ff @(posedge aclk) begin
        if (load) begin
            skid_q <= rx_data;
        end
    end

    // Output mux: skid slot when full, else straight through
    always_comb begin
        if (full) begin
            tx_tvalid = 1'b1;                    // Stored beat always valid
            tx_data   = skid_q;
        end else begin
            tx_tvalid = rx_tvalid;               // Zero-latency path
            tx_data   = rx_data;
        end
    end

    // A stalled beat stays put until taken, relies on the upstream holding its beat too
    assert property (@(posedge aclk) disable iff (!rst_n)
        tx_tvalid && !tx_tready |=> tx_tvalid && $stable(tx_data))
    else $error("skid_buffer: tx beat changed while stalled");

    // Ready flop must track the full flag
    assert property (@(posedge aclk) disable iff (!rst_n)
        full |-> !rx_tready)
    else $error("skid_buffer: rx_tready high with skid register full");

endmodule

`default_nettype wire

//--- hw/axis_skid_buffer.sv
// AXI4-Stream skid stage: packs the beat, buffers it and ties off disabled fields
`timescale 1ns/1ps
`default_nettype none

module axis_skid_buffer import axis_pkg::*; #(
    parameter int USE_TLAST = 1,                 // 0 drops tlast, tx_tlast tied high
    parameter int USE_TKEEP = 1,                 // 0 drops tkeep, tx_tkeep all ones
    parameter int USE_TSTRB = 1                  // 0 drops tstrb, tx_tstrb all ones
) (
    input  logic                         aclk,
    input  logic                         rst_n,

    input  logic                         rx_tvalid,
    output logic                         rx_tready,
    input  logic [AXIS_DATA_BYTES*8-1:0] rx_tdata,
    input  logic [AXIS_DATA_BYTES-1:0]   rx_tstrb,
    input  logic [AXIS_DATA_BYTES-1:0]   rx_tkeep,
    input  logic                         rx_tlast,
    input  logic [AXIS_DEST_WIDTH-1:0]   rx_tdest,
    input  logic [AXIS_USER_WIDTH-1:0]   rx_tuser,
    input  logic [AXIS_ID_WIDTH-1:0]     rx_tid,

    output logic                         tx_tvalid,
    input  logic                         tx_tready,
    output logic [AXIS_DATA_BYTES*8-1:0] tx_tdata,
    output logic [AXIS_DATA_BYTES-1:0]   tx_tstrb,
    output logic [AXIS_DATA_BYTES-1:0]   tx_tkeep,
    output logic                         tx_tlast,
    output logic [AXIS_DEST_WIDTH-1:0]   tx_tdest,
    output logic [AXIS_USER_WIDTH-1:0]   tx_tuser,
    output logic [AXIS_ID_WIDTH-1:0]     tx_tid
);

    axis_beat_t                 rx_beat;         // Packed incoming beat
    axis_beat_t                 tx_beat;         // Buffered beat
    logic [AXIS_DATA_BYTES-1:0] strb_in;         // Field value as stored
    logic [AXIS_DATA_BYTES-1:0] keep_in;
    logic                       last_in;

    // Optional fields
    // A disabled field stores a constant, so synthesis folds its flops away
    if (USE_TSTRB != 0) begin : g_tstrb_on
        assign strb_in  = rx_tstrb;
        assign tx_tstrb = tx_beat.tstrb;
    end else begin : g_tstrb_off
        logic unused_tstrb;                      // Lint sink for dead bits
        assign strb_in      = '1;
        assign tx_tstrb     = '1;
        assign unused_tstrb = &{1'b0, rx_tstrb, tx_beat.tstrb};
    end

    if (USE_TKEEP != 0) begin : g_tkeep_on
        assign keep_in  = rx_tkeep;
        assign tx_tkeep = tx_beat.tkeep;
    end else begin : g_tkeep_off
        logic unused_tkeep;
        assign keep_in      = '1;
        assign tx_tkeep     = '1;               // Every byte kept
        assign unused_tkeep = &{1'b0, rx_tkeep, tx_beat.tkeep};
    end

    if (USE_TLAST != 0) begin : g_tlast_on
        assign last_in  = rx_tlast;
        assign tx_tlast = tx_beat.tlast;
    end else begin : g_tlast_off
        logic unused_tlast;
        assign last_in      = 1'b1;
        assign tx_tlast     = 1'b1;             // Every beat ends a packet
        assign unused_tlast = &{1'b0, rx_tlast, tx_beat.tlast};
    end

    // Pack
    always_comb begin
        rx_beat.tdata = rx_tdata;
        rx_beat.tstrb = strb_in;
        rx_beat.tkeep = keep_in;
        rx_beat.tlast = last_in;
        rx_beat.tdest = rx_tdest;
        rx_beat.tuser = rx_tuser;
        rx_beat.tid   = rx_tid;
    end

    skid_buffer #(
        .payload_t (axis_beat_t)
    ) skid_buffer_i (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .rx_tvalid (rx_tvalid),
        .rx_tready (rx_tready),
        .rx_data   (rx_beat),
        .tx_tvalid (tx_tvalid),
        .tx_tready (tx_tready),
        .tx_data   (tx_beat)
    );

    // Unpack, mandatory fields
    assign tx_tdata = tx_beat.tdata;
    assign tx_tdest = tx_beat.tdest;
    assign tx_tuser = tx_beat.tuser;
    assign tx_tid   = tx_beat.tid;

endmodule

`default_nettype wire

//--- hw/axis_register_slice.sv
// AXI4-Stream register slice built from a chain of zero-latency skid stages
`timescale 1ns/1ps
`default_nettype none

module axis_register_slice import axis_pkg::*; #(
    parameter int STAGES    = 2,                 // Skid stages, also beats held under stall
    parameter int USE_TLAST = 1,
    parameter int USE_TKEEP = 1,
    parameter int USE_TSTRB = 1
) (
    input  logic                         aclk,
    input  logic                         rst_n,

    input  logic                         rx_tvalid,
    output logic                         rx_tready,
    input  logic [AXIS_DATA_BYTES*8-1:0] rx_tdata,
    input  logic [AXIS_DATA_BYTES-1:0]   rx_tstrb,
    input  logic [AXIS_DATA_BYTES-1:0]   rx_tkeep,
    input  logic                         rx_tlast,
    input  logic [AXIS_DEST_WIDTH-1:0]   rx_tdest,
    input  logic [AXIS_USER_WIDTH-1:0]   rx_tuser,
    input  logic [AXIS_ID_WIDTH-1:0]     rx_tid,

    output logic                         tx_tvalid,
    input  logic                         tx_tready,
    output logic [AXIS_DATA_BYTES*8-1:0] tx_tdata,
    output logic [AXIS_DATA_BYTES-1:0]   tx_tstrb,
    output logic [AXIS_DATA_BYTES-1:0]   tx_tkeep,
    output logic                         tx_tlast,
    output logic [AXIS_DEST_WIDTH-1:0]   tx_tdest,
    output logic [AXIS_USER_WIDTH-1:0]   tx_tuser,
    output logic [AXIS_ID_WIDTH-1:0]     tx_tid
);

    // Link k feeds stage k, link STAGES is the output
    logic [STAGES:0]              tvalid_w;
    logic [STAGES:0]              tready_w;
    logic [AXIS_DATA_BYTES*8-1:0] tdata_w [0:STAGES];
    logic [AXIS_DATA_BYTES-1:0]   tstrb_w [0:STAGES];
    logic [AXIS_DATA_BYTES-1:0]   tkeep_w [0:STAGES];
    logic [STAGES:0]              tlast_w;
    logic [AXIS_DEST_WIDTH-1:0]   tdest_w [0:STAGES];
    logic [AXIS_USER_WIDTH-1:0]   tuser_w [0:STAGES];
    logic [AXIS_ID_WIDTH-1:0]     tid_w   [0:STAGES];

    // Chain ends
    assign tvalid_w[0] = rx_tvalid;
    assign rx_tready   = tready_w[0];            // Straight from the first stage's flop
    assign tdata_w[0]  = rx_tdata;
    assign tstrb_w[0]  = rx_tstrb;
    assign tkeep_w[0]  = rx_tkeep;
    assign tlast_w[0]  = rx_tlast;
    assign tdest_w[0]  = rx_tdest;
    assign tuser_w[0]  = rx_tuser;
    assign tid_w[0]    = rx_tid;

    assign tx_tvalid        = tvalid_w[STAGES];
    assign tready_w[STAGES] = tx_tready;
    assign tx_tdata         = tdata_w[STAGES];
    assign tx_tstrb         = tstrb_w[STAGES];
    assign tx_tkeep         = tkeep_w[STAGES];
    assign tx_tlast         = tlast_w[STAGES];
    assign tx_tdest         = tdest_w[STAGES];
    assign tx_tuser         = tuser_w[STAGES];
    assign tx_tid           = tid_w[STAGES];

    for (genvar k = 0; k < STAGES; k++) begin : g_stage
        axis_skid_buffer #(
            .USE_TLAST (USE_TLAST),
            .USE_TKEEP (USE_TKEEP),
            .USE_TSTRB (USE_TSTRB)
        ) axis_skid_buffer_i (
            .aclk      (aclk),
            .rst_n     (rst_n),
            .rx_tvalid (tvalid_w[k]),
            .rx_tready (tready_w[k]),
            .rx_tdata  (tdata_w[k]),
            .rx_tstrb  (tstrb_w[k]),
            .rx_tkeep  (tkeep_w[k]),
            .rx_tlast  (tlast_w[k]),
            .rx_tdest  (tdest_w[k]),
            .rx_tuser  (tuser_w[k]),
            .rx_tid    (tid_w[k]),
            .tx_tvalid (tvalid_w[k+1]),
            .tx_tready (tready_w[k+1]),
            .tx_tdata  (tdata_w[k+1]),
            .tx_tstrb  (tstrb_w[k+1]),
            .tx_tkeep  (tkeep_w[k+1]),
            .tx_tlast  (tlast_w[k+1]),
            .tx_tdest  (tdest_w[k+1]),
            .tx_tuser  (tuser_w[k+1]),
            .tx_tid    (tid_w[k+1])
        );
    end

endmodule

`default_nettype wire

//--- dv/axis_register_slice_tb_checks.svh
// Reference model, xorshift generator and compare tasks for the register slice testbench
`ifndef AXIS_REGISTER_SLICE_TB_CHECKS_SVH
`define AXIS_REGISTER_SLICE_TB_CHECKS_SVH

axis_beat_t  expected_q [$];                     // Accepted on rx, not yet seen on tx
logic [31:0] rng_state = 32'd15580;              // Generator state

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

function automatic logic [31:0] draw_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
endfunction

// Random word on top, low 18 bits fill tstrb through tid
function automatic axis_beat_t random_beat();
    logic [31:0] word;
    logic [31:0] side;
    word = draw_random();
    side = draw_random();
    return {word, side[17:0]};
endfunction

// What the slice should deliver for a given input beat
function automatic axis_beat_t expected_beat(input axis_beat_t sent);
    axis_beat_t e;
    e = sent;
    if (USE_TSTRB == 0) begin
        e.tstrb = '1;                            // Dropped field reads all ones
    end
    if (USE_TKEEP == 0) begin
        e.tkeep = '1;
    end
    if (USE_TLAST == 0) begin
        e.tlast = 1'b1;
    end
    return e;
endfunction

task automatic check_beat(input string name, input axis_beat_t expected, input axis_beat_t actual);
    if (actual !== expected) begin
        beat_errors++;
        $display("ERROR %s at %0t: expected %h, actual %h", name, $time, expected, actual);
    end
endtask

task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        flag_errors++;
        $display("ERROR %s at %0t: expected %b, actual %b", name, $time, expected, actual);
    end
endtask

task automatic check_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
        count_errors++;
        $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
    end
endtask

`endif

//--- dv/axis_register_slice_tb.sv
// Testbench for the AXI4-Stream register slice covering throughput, back-pressure and depth
`timescale 1ns/1ps
`default_nettype none

module axis_register_slice_tb
    import axis_pkg::*;
();

    localparam int STAGES         = 3;
    localparam int USE_TLAST      = 1;
    localparam int USE_TKEEP      = 1;
    localparam int USE_TSTRB      = 0;           // tstrb dropped in this build
    localparam int FULL_BEATS     = 64;
    localparam int RAND_BEATS     = 300;
    localparam int DEPTH_BEATS    = STAGES + 1;  // Chain filled plus one held at rx
    localparam int TOTAL_BEATS    = FULL_BEATS + RAND_BEATS + DEPTH_BEATS;
    localparam int TIMEOUT_CYCLES = 4 * TOTAL_BEATS + 200;

    localparam logic [1:0] READY_LOW  = 2'd0;
    localparam logic [1:0] READY_HIGH = 2'd1;
    localparam logic [1:0] READY_RAND = 2'd2;

    logic                         aclk;
    logic                         rst_n;
    logic                         rx_tvalid;
    logic                         rx_tready;
    logic [AXIS_DATA_BYTES*8-1:0] rx_tdata;
    logic [AXIS_DATA_BYTES-1:0]   rx_tstrb;
    logic [AXIS_DATA_BYTES-1:0]   rx_tkeep;
    logic                         rx_tlast;
    logic [AXIS_DEST_WIDTH-1:0]   rx_tdest;
    logic [AXIS_USER_WIDTH-1:0]   rx_tuser;
    logic [AXIS_ID_WIDTH-1:0]     rx_tid;
    logic                         tx_tvalid;
    logic                         tx_tready;
    logic [AXIS_DATA_BYTES*8-1:0] tx_tdata;
    logic [AXIS_DATA_BYTES-1:0]   tx_tstrb;
    logic [AXIS_DATA_BYTES-1:0]   tx_tkeep;
    logic                         tx_tlast;
    logic [AXIS_DEST_WIDTH-1:0]   tx_tdest;
    logic [AXIS_USER_WIDTH-1:0]   tx_tuser;
    logic [AXIS_ID_WIDTH-1:0]     tx_tid;

    logic [1:0] ready_mode;                      // How tx_tready moves each cycle
    string      test_name;
    int         cycle_count  = 0;
    int         rx_count     = 0;                // Beats accepted at the input
    int         tx_count     = 0;                // Beats delivered at the output
    int         beat_errors  = 0;
    int         flag_errors  = 0;
    int         count_errors = 0;
    int         other_errors = 0;
    logic       stalled      = 1'b0;             // Output beat waited last cycle
    axis_beat_t stall_beat;                      // The beat that waited

    `include "axis_register_slice_tb_checks.svh"

    axis_register_slice #(
        .STAGES    (STAGES),
        .USE_TLAST (USE_TLAST),
        .USE_TKEEP (USE_TKEEP),
        .USE_TSTRB (USE_TSTRB)
    ) axis_register_slice_i (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .rx_tvalid (rx_tvalid),
        .rx_tready (rx_tready),
        .rx_tdata  (rx_tdata),
        .rx_tstrb  (rx_tstrb),
        .rx_tkeep  (rx_tkeep),
        .rx_tlast  (rx_tlast),
        .rx_tdest  (rx_tdest),
        .rx_tuser  (rx_tuser),
        .rx_tid    (rx_tid),
        .tx_tvalid (tx_tvalid),
        .tx_tready (tx_tready),
        .tx_tdata  (tx_tdata),
        .tx_tstrb  (tx_tstrb),
        .tx_tkeep  (tx_tkeep),
        .tx_tlast  (tx_tlast),
        .tx_tdest  (tx_tdest),
        .tx_tuser  (tx_tuser),
        .tx_tid    (tx_tid)
    );

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;                 // 10 ns period
    end

    function automatic axis_beat_t pack_rx();
        return {rx_tdata, rx_tstrb, rx_tkeep, rx_tlast, rx_tdest, rx_tuser, rx_tid};
    endfunction

    function automatic axis_beat_t pack_tx();
        return {tx_tdata, tx_tstrb, tx_tkeep, tx_tlast, tx_tdest, tx_tuser, tx_tid};
    endfunction

    task automatic put_rx(input axis_beat_t beat);
        {rx_tdata, rx_tstrb, rx_tkeep, rx_tlast, rx_tdest, rx_tuser, rx_tid} = beat;
    endtask

    // Step to 1 ns past the next rising edge
    task automatic next_cycle();
        logic [31:0] r;
        @(posedge aclk);
        #1;
        if (ready_mode == READY_RAND) begin
            r         = draw_random();
            tx_tready = r[0];
        end
    endtask

    task automatic wait_accept();
        logic taken;
        taken = 1'b0;
        while (!taken) begin
            taken = rx_tready;                   // Registered, steady until the edge
            next_cycle();
        end
    endtask

    // Payload held with tvalid until taken
    task automatic send_beat(input axis_beat_t beat);
        put_rx(beat);
        rx_tvalid = 1'b1;
        wait_accept();
    endtask

    task automatic drain_output();
        while (expected_q.size() != 0) begin
            next_cycle();
        end
    endtask

    task automatic report_counts();
        $display("Errors: beat %0d, flag %0d, count %0d, other %0d",
                 beat_errors, flag_errors, count_errors, other_errors);
    endtask

    // Handshakes sampled at the falling edge, clear of both drive and register updates
    always @(negedge aclk) begin : monitor
        axis_beat_t tx_now;
        if (rst_n) begin
            tx_now = pack_tx();
            if (stalled) begin                   // Held beat must not move
                check_bit({test_name, " stall tvalid"}, 1'b1, tx_tvalid);
                check_beat({test_name, " stall beat"}, stall_beat, tx_now);
            end
            if (rx_tvalid && rx_tready) begin
                expected_q.push_back(expected_beat(pack_rx()));
                rx_count++;
            end
            if (tx_tvalid && tx_tready) begin
                tx_count++;
                if (expected_q.size() == 0) begin
                    other_errors++;
                    $display("%s: output beat %h arrived with no input beat behind it",
                             test_name, tx_now);
                end else begin
                    check_beat(test_name, expected_q.pop_front(), tx_now);
                end
            end
            stalled    = tx_tvalid && !tx_tready;
            stall_beat = tx_now;
        end
    end

    always @(posedge aclk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            other_errors++;
            $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
            report_counts();
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin : stimulus
        int          accepted;
        logic [31:0] r;

        rst_n      = 1'b0;
        rx_tvalid  = 1'b0;
        tx_tready  = 1'b0;
        ready_mode = READY_LOW;
        test_name  = "reset";
        put_rx('0);

        // Reset state, two cycles in reset and one after
        repeat (2) begin
            @(posedge aclk);
            #1;
            check_bit("reset rx_tready", 1'b1, rx_tready);
            check_bit("reset tx_tvalid", 1'b0, tx_tvalid);
        end
        rst_n = 1'b1;
        next_cycle();
        check_bit("post reset rx_tready", 1'b1, rx_tready);
        check_bit("post reset tx_tvalid", 1'b0, tx_tvalid);

        // Back-to-back beats, ready never drops
        test_name  = "full_rate";
        ready_mode = READY_HIGH;
        tx_tready  = 1'b1;
        for (int i = 0; i < FULL_BEATS; i++) begin
            check_bit("full_rate rx_tready", 1'b1, rx_tready);
            send_beat(random_beat());
        end
        rx_tvalid = 1'b0;
        drain_output();

        // Random gaps on rx, random back-pressure on tx
        test_name  = "random";
        ready_mode = READY_RAND;
        for (int i = 0; i < RAND_BEATS; i++) begin
            r = draw_random();
            if (r[1:0] == 2'd0) begin            // Idle cycle
                rx_tvalid = 1'b0;
                next_cycle();
            end
            send_beat(random_beat());
        end
        rx_tvalid  = 1'b0;
        ready_mode = READY_HIGH;
        tx_tready  = 1'b1;
        drain_output();

        // Output stalled, count what the chain soaks up
        test_name  = "depth";
        ready_mode = READY_LOW;
        tx_tready  = 1'b0;
        accepted   = 0;
        put_rx(random_beat());
        rx_tvalid  = 1'b1;
        repeat (STAGES + 3) begin
            if (rx_tready) begin
                accepted++;
                next_cycle();
                put_rx(random_beat());           // Next beat once the last was taken
            end else begin
                next_cycle();
            end
        end
        check_count("depth beats held", STAGES, accepted);
        check_bit("depth rx_tready", 1'b0, rx_tready);
        ready_mode = READY_HIGH;
        tx_tready  = 1'b1;
        wait_accept();                           // Beat held at rx goes in last
        rx_tvalid = 1'b0;
        drain_output();

        check_count("rx beats", TOTAL_BEATS, rx_count);
        check_count("tx beats", TOTAL_BEATS, tx_count);
        report_counts();
        if (beat_errors + flag_errors + count_errors + other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- axis_register_slice.f
+incdir+dv
hw/axis_pkg.sv
hw/skid_buffer.sv
hw/axis_skid_buffer.sv
hw/axis_register_slice.sv
dv/axis_register_slice_tb.sv

//--- Makefile
# Verilator flow for the AXI4-Stream register slice

VERILATOR  ?= verilator
TOP        := axis_register_slice_tb
FILELIST   := axis_register_slice.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -j 0
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := PASS: all tests
FAIL_MSG   := FAIL: see errors above

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
